// File: CoreSystem.f
hdl/CoreTypes.sv
hdl/RegisterFile.sv
hdl/FetchUnit.sv
hdl/ExecuteUnit.sv
hdl/LoadStoreUnit.sv
hdl/MemoryAccessController.sv
hdl/Core.sv
hdl/MainMemory.sv
hdl/CoreSystem.sv
verif/CoreSystemTb.sv

// File: run.sh
#!/bin/sh
# Build and run the core subsystem simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f CoreSystem.f --top-module CoreSystemTb -o CoreSystemSim
./obj_dir/CoreSystemSim | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1

// File: verif/CoreSystemTb.sv
// Core subsystem testbench
`timescale 1ns/1ns
`default_nettype none

module CoreSystemTb;
    import CoreTypes::*;

    localparam int NUM_TESTS = 4;
    localparam int MAX_WORDS = 16;
    localparam int MAX_SERIAL = 8;
    localparam int HALT_TIMEOUT = 2000;

    logic    clk = 1'b0;
    logic    arstN;
    logic    progWE;
    AddrPath progAddr;
    DataPath progData;
    logic    run;
    logic    serialWE;
    DataPath serialWriteData;
    logic    halted;
    logic    illegalOp;
    PC_Path  lastCommittedPC;
    logic    commitValid;

    // Stimulus and expected results, one row per test
    string   testName [NUM_TESTS];
    DataPath progWords [NUM_TESTS][MAX_WORDS];
    int      progLen [NUM_TESTS];
    DataPath expSerial [NUM_TESTS][MAX_SERIAL];
    int      expSerialCount [NUM_TESTS];
    int      expLastPC [NUM_TESTS];
    int      expCommits [NUM_TESTS];
    bit      expIllegal [NUM_TESTS];

    string   currentTest;
    DataPath serialSeen [$];
    int      commitCount = 0;
    int      checksRun = 0;
    int      valueErrors = 0;
    int      timeoutErrors = 0;

    CoreSystem DUT (
        .clk(clk), .arstN(arstN),
        .progWE(progWE), .progAddr(progAddr), .progData(progData),
        .run(run),
        .serialWE(serialWE), .serialWriteData(serialWriteData),
        .halted(halted), .illegalOp(illegalOp),
        .lastCommittedPC(lastCommittedPC), .commitValid(commitValid)
    );

    always #20 clk = ~clk;

    // Serial and commit monitor
    always @(negedge clk) begin
        if (arstN === 1'b1) begin
            if (serialWE) begin
                serialSeen.push_back(serialWriteData);
            end
            if (commitValid) begin
                commitCount++;
            end
        end
    end

    function automatic DataPath encodeInstr(logic [3:0] op, int rd, int rs1, int rs2, int imm);
        return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000, imm[15:0]};
    endfunction

    // r0 plus -1 wraps to the top word
    function automatic DataPath serialStore(int rs);
        return encodeInstr(OP_SW, 0, 0, rs, -1);
    endfunction

    task automatic appendWord(int row, DataPath word);
        progWords[row][progLen[row]] = word;
        progLen[row]++;
    endtask

    task automatic appendSerial(int row, DataPath value);
        expSerial[row][expSerialCount[row]] = value;
        expSerialCount[row]++;
    endtask

    task automatic buildTable();
        int a;
        int b;
        a = int'($urandom % 4096) - 2048;
        b = int'($urandom % 4096) - 2048;
        for (int r = 0; r < NUM_TESTS; r++) begin
            progLen[r] = 0;
            expSerialCount[r] = 0;
            for (int i = 0; i < MAX_WORDS; i++) begin
                progWords[r][i] = '0;
            end
        end
        testName[0] = "arith";
        appendWord(0, encodeInstr(OP_ADDI, 1, 0, 0, a));
        appendWord(0, encodeInstr(OP_ADDI, 2, 0, 0, b));
        appendWord(0, encodeInstr(OP_ADD, 3, 1, 2, 0));
        appendWord(0, encodeInstr(OP_SUB, 4, 1, 2, 0));
        appendWord(0, encodeInstr(OP_ADDI, 0, 0, 0, 55));
        appendWord(0, encodeInstr(OP_ADD, 5, 0, 1, 0));
        appendWord(0, serialStore(3));
        appendWord(0, serialStore(4));
        appendWord(0, serialStore(5));
        appendWord(0, serialStore(0));
        appendWord(0, encodeInstr(OP_HALT, 0, 0, 0, 0));
        appendSerial(0, DataPath'(a + b));
        appendSerial(0, DataPath'(a - b));
        appendSerial(0, DataPath'(a));
        appendSerial(0, '0);
        expLastPC[0] = 10;
        expCommits[0] = 11;
        expIllegal[0] = 1'b0;

        testName[1] = "memory";
        appendWord(1, encodeInstr(OP_ADDI, 1, 0, 0, 'h123));
        appendWord(1, encodeInstr(OP_ADDI, 2, 0, 0, -7));
        appendWord(1, encodeInstr(OP_ADDI, 7, 0, 0, 100));
        appendWord(1, encodeInstr(OP_SW, 0, 7, 1, 0));
        appendWord(1, encodeInstr(OP_SW, 0, 7, 2, 1));
        appendWord(1, encodeInstr(OP_LW, 3, 7, 0, 1));
        appendWord(1, encodeInstr(OP_LW, 4, 7, 0, 0));
        appendWord(1, serialStore(3));
        appendWord(1, serialStore(4));
        appendWord(1, encodeInstr(OP_ADD, 5, 3, 4, 0));
        appendWord(1, serialStore(5));
        appendWord(1, encodeInstr(OP_HALT, 0, 0, 0, 0));
        appendSerial(1, 32'hFFFF_FFF9);
        appendSerial(1, 32'h0000_0123);
        appendSerial(1, 32'h0000_011C);
        expLastPC[1] = 11;
        expCommits[1] = 12;
        expIllegal[1] = 1'b0;

        // Count down from 4, branching back to the store
        testName[2] = "loop";
        appendWord(2, encodeInstr(OP_ADDI, 1, 0, 0, 4));
        appendWord(2, serialStore(1));
        appendWord(2, encodeInstr(OP_ADDI, 1, 1, 0, -1));
        appendWord(2, encodeInstr(OP_BNE, 0, 1, 0, -2));
        appendWord(2, encodeInstr(OP_HALT, 0, 0, 0, 0));
        for (int n = 4; n > 0; n--) begin
            appendSerial(2, DataPath'(n));
        end
        expLastPC[2] = 4;
        expCommits[2] = 14;
        expIllegal[2] = 1'b0;

        testName[3] = "illegal";
        appendWord(3, encodeInstr(OP_ADDI, 1, 0, 0, 9));
        appendWord(3, serialStore(1));
        appendWord(3, encodeInstr(4'hC, 0, 0, 0, 0));
        appendWord(3, serialStore(1));
        appendWord(3, encodeInstr(OP_HALT, 0, 0, 0, 0));
        appendSerial(3, 32'd9);
        expLastPC[3] = 1;
        expCommits[3] = 2;
        expIllegal[3] = 1'b1;
    endtask

    task automatic checkValue(string what, DataPath expected, DataPath actual);
        checksRun++;
        assert (actual === expected) else begin
            valueErrors++;
            $display("[FAIL] %s %s: expected %h, actual %h", currentTest, what, expected,
                     actual);
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        arstN  <= 1'b0;
        progWE <= 1'b0;
        run    <= 1'b0;
        repeat (4) @(posedge clk);
        serialSeen.delete();
        commitCount = 0;
        arstN <= 1'b1;
    endtask

    // Core must stay quiet until run
    task automatic checkIdle();
        checkValue("idle strobes", '0, 32'({serialWE, halted, illegalOp, commitValid}));
        checkValue("idle lastCommittedPC", '0, 32'(lastCommittedPC));
    endtask

    task automatic loadProgram(int row);
        for (int i = 0; i < MAX_WORDS; i++) begin
            @(posedge clk);
            progWE   <= 1'b1;
            progAddr <= AddrPath'(i);
            progData <= progWords[row][i];
            @(negedge clk);
            checkIdle();
        end
        @(posedge clk);
        progWE <= 1'b0;
        @(negedge clk);
        checkIdle();
    endtask

    task automatic pulseRun();
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic waitForHalt();
        int waited;
        waited = 0;
        while (halted !== 1'b1 && waited < HALT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (halted === 1'b1) else begin
            timeoutErrors++;
            $display("Timeout: test %s did not halt within %0d cycles", currentTest,
                     HALT_TIMEOUT);
        end
    endtask

    task automatic checkRow(int row);
        int shown;
        // Let any late serial strobe show up
        repeat (4) @(negedge clk);
        checkValue("halted", 32'd1, 32'(halted));
        checkValue("illegalOp", 32'(expIllegal[row]), 32'(illegalOp));
        checkValue("lastCommittedPC", 32'(expLastPC[row]), 32'(lastCommittedPC));
        checkValue("commit count", 32'(expCommits[row]), 32'(commitCount));
        checkValue("serial count", 32'(expSerialCount[row]), 32'(serialSeen.size()));
        shown = serialSeen.size();
        if (expSerialCount[row] < shown) begin
            shown = expSerialCount[row];
        end
        for (int i = 0; i < shown; i++) begin
            checkValue($sformatf("serial[%0d]", i), expSerial[row][i], serialSeen[i]);
        end
    endtask

    initial begin
        void'($urandom(46));
        arstN    <= 1'b0;
        progWE   <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        run      <= 1'b0;
        buildTable();
        for (int row = 0; row < NUM_TESTS; row++) begin
            currentTest = testName[row];
            resetDut();
            loadProgram(row);
            pulseRun();
            waitForHalt();
            checkRow(row);
        end
        $display("Checks: %0d, value errors: %0d, timeouts: %0d", checksRun, valueErrors,
                 timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : CoreSystemTb

`default_nettype wire

// File: hdl/CoreSystem.sv
// Core and memory subsystem
`timescale 1ns/1ns
`default_nettype none

module CoreSystem (
    input  logic             clk,
    input  logic             arstN,
    input  logic             progWE,
    input  CoreTypes::AddrPath progAddr,
    input  CoreTypes::DataPath progData,
    input  logic             run,
    output logic             serialWE,
    output CoreTypes::DataPath serialWriteData,
    output logic             halted,
    output logic             illegalOp,
    output CoreTypes::PC_Path  lastCommittedPC,
    output logic             commitValid
);
    import CoreTypes::*;

    AddrPath        memAccessAddr;
    DataPath        memAccessWriteData;
    logic           memAccessRE;
    logic           memAccessWE;
    MemAccessSerial memAccessSerial;
    logic           memAccessBusy;
    logic           memReadDataReady;
    DataPath        memReadData;
    MemAccessSerial memReadSerial;

    Core core (
        .clk(clk), .arstN(arstN), .run(run),
        .memAccessAddr(memAccessAddr), .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE), .memAccessWE(memAccessWE),
        .memAccessSerial(memAccessSerial), .memAccessBusy(memAccessBusy),
        .memReadDataReady(memReadDataReady), .memReadData(memReadData),
        .memReadSerial(memReadSerial),
        .serialWE(serialWE), .serialWriteData(serialWriteData),
        .halted(halted), .illegalOp(illegalOp),
        .lastCommittedPC(lastCommittedPC), .commitValid(commitValid)
    );

    MainMemory mainMemory (
        .clk(clk), .arstN(arstN),
        .progWE(progWE), .progAddr(progAddr), .progData(progData),
        .memAccessAddr(memAccessAddr), .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE), .memAccessWE(memAccessWE),
        .memAccessSerial(memAccessSerial), .memAccessBusy(memAccessBusy),
        .memReadDataReady(memReadDataReady), .memReadData(memReadData),
        .memReadSerial(memReadSerial)
    );

endmodule : CoreSystem

`default_nettype wire

// File: hdl/MainMemory.sv
// Pipelined word memory model
`timescale 1ns/1ns
`default_nettype none

module MainMemory (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     progWE,
    input  CoreTypes::AddrPath        progAddr,
    input  CoreTypes::DataPath        progData,
    input  CoreTypes::AddrPath        memAccessAddr,
    input  CoreTypes::DataPath        memAccessWriteData,
    input  logic                     memAccessRE,
    input  logic                     memAccessWE,
    input  CoreTypes::MemAccessSerial memAccessSerial,
    output logic                     memAccessBusy,
    output logic                     memReadDataReady,
    output CoreTypes::DataPath        memReadData,
    output CoreTypes::MemAccessSerial memReadSerial
);
    import CoreTypes::*;

    DataPath                     memArray [2**ADDR_WIDTH];
    logic [MEM_READ_LATENCY-1:0] pipeValid;
    MemAccessSerial              pipeSerial [MEM_READ_LATENCY];
    DataPath                     pipeData [MEM_READ_LATENCY];

    // Program loading owns the array
    assign memAccessBusy = progWE;

    always_ff @(posedge clk) begin
        if (progWE) begin
            memArray[progAddr] <= progData;
        end else if (memAccessWE) begin
            memArray[memAccessAddr] <= memAccessWriteData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= '0;
        end else begin
            pipeValid <= {pipeValid[MEM_READ_LATENCY-2:0], memAccessRE && !progWE};
        end
    end

    always_ff @(posedge clk) begin
        pipeSerial[0] <= memAccessSerial;
        pipeData[0]   <= memArray[memAccessAddr];
        for (int i = 1; i < MEM_READ_LATENCY; i++) begin
            pipeSerial[i] <= pipeSerial[i-1];
            pipeData[i]   <= pipeData[i-1];
        end
    end

    assign memReadDataReady = pipeValid[MEM_READ_LATENCY-1];
    assign memReadSerial    = pipeSerial[MEM_READ_LATENCY-1];
    assign memReadData      = pipeData[MEM_READ_LATENCY-1];

endmodule : MainMemory

`default_nettype wire

// File: hdl/Core.sv
// Multi-cycle core
`timescale 1ns/1ns
`default_nettype none

module Core (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     run,
    output CoreTypes::AddrPath        memAccessAddr,
    output CoreTypes::DataPath        memAccessWriteData,
    output logic                     memAccessRE,
    output logic                     memAccessWE,
    output CoreTypes::MemAccessSerial memAccessSerial,
    input  logic                     memAccessBusy,
    input  logic                     memReadDataReady,
    input  CoreTypes::DataPath        memReadData,
    input  CoreTypes::MemAccessSerial memReadSerial,
    output logic                     serialWE,
    output CoreTypes::DataPath        serialWriteData,
    output logic                     halted,
    output logic                     illegalOp,
    output CoreTypes::PC_Path         lastCommittedPC,
    output logic                     commitValid
);
    import CoreTypes::*;

    CorePhase   phase;
    CorePhase   nextPhase;
    logic       commitStrobe;
    logic       memDone;
    PC_Path     pc;
    DataPath    instruction;
    logic       fetchReq;
    logic       fetchDone;
    DataPath    fetchData;
    RegAddrPath rs1Addr;
    RegAddrPath rs2Addr;
    RegAddrPath rdAddr;
    DataPath    rs1Data;
    DataPath    rs2Data;
    DataPath    rdData;
    logic       rdWrite;
    logic       branchTaken;
    PC_Path     branchOffset;
    logic       memRead;
    logic       memWrite;
    AddrPath    memAddr;
    DataPath    storeData;
    logic       isHalt;
    logic       isIllegal;
    logic       dataReadReq;
    logic       dataWriteReq;
    AddrPath    dataAddr;
    DataPath    dataWriteData;
    logic       dataDone;
    DataPath    dataReadData;
    DataPath    loadData;
    logic       ioStore;

    always_comb begin
        nextPhase    = phase;
        commitStrobe = 1'b0;
        case (phase)
            PH_IDLE: begin
                if (run) begin
                    nextPhase = PH_FETCH;
                end
            end
            PH_FETCH: begin
                if (!memAccessBusy) begin
                    nextPhase = PH_FETCH_WAIT;
                end
            end
            PH_FETCH_WAIT: begin
                if (fetchDone) begin
                    nextPhase = PH_EXECUTE;
                end
            end
            PH_EXECUTE: begin
                if (isIllegal) begin
                    nextPhase = PH_HALTED;
                end else if ((memRead || memWrite) && !ioStore) begin
                    if (!memAccessBusy) begin
                        nextPhase = PH_MEM_WAIT;
                    end
                end else begin
                    commitStrobe = 1'b1;
                    nextPhase = isHalt ? PH_HALTED : PH_FETCH;
                end
            end
            PH_MEM_WAIT: begin
                // Load data is registered, so commit one cycle after dataDone
                if (memDone) begin
                    commitStrobe = 1'b1;
                    nextPhase = PH_FETCH;
                end
            end
            default: nextPhase = phase;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase           <= PH_IDLE;
            memDone         <= 1'b0;
            commitValid     <= 1'b0;
            lastCommittedPC <= '0;
            illegalOp       <= 1'b0;
        end else begin
            phase       <= nextPhase;
            memDone     <= dataDone;
            commitValid <= commitStrobe;
            if (commitStrobe) begin
                lastCommittedPC <= pc;
            end
            if (phase == PH_EXECUTE && isIllegal) begin
                illegalOp <= 1'b1;
            end
        end
    end

    assign halted = phase == PH_HALTED;

    FetchUnit fetchUnit (
        .clk(clk), .arstN(arstN), .phase(phase),
        .fetchDone(fetchDone), .fetchData(fetchData),
        .branchTaken(branchTaken), .branchOffset(branchOffset),
        .commitStrobe(commitStrobe),
        .pc(pc), .instruction(instruction), .fetchReq(fetchReq)
    );

    ExecuteUnit executeUnit (
        .instruction(instruction), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .loadData(loadData),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .rdWrite(rdWrite), .rdData(rdData),
        .branchTaken(branchTaken), .branchOffset(branchOffset),
        .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr),
        .storeData(storeData), .isHalt(isHalt), .isIllegal(isIllegal)
    );

    RegisterFile registerFile (
        .clk(clk), .arstN(arstN),
        .readAddrA(rs1Addr), .readAddrB(rs2Addr),
        .readDataA(rs1Data), .readDataB(rs2Data),
        .writeEnable(commitStrobe && rdWrite),
        .writeAddr(rdAddr), .writeData(rdData)
    );

    LoadStoreUnit loadStoreUnit (
        .clk(clk), .arstN(arstN), .phase(phase),
        .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr),
        .storeData(storeData), .dataDone(dataDone), .dataReadData(dataReadData),
        .dataReadReq(dataReadReq), .dataWriteReq(dataWriteReq),
        .dataAddr(dataAddr), .dataWriteData(dataWriteData),
        .loadData(loadData), .ioStore(ioStore),
        .serialWE(serialWE), .serialWriteData(serialWriteData)
    );

    MemoryAccessController memoryAccessController (
        .clk(clk), .arstN(arstN),
        .fetchReq(fetchReq), .fetchAddr(pc),
        .dataReadReq(dataReadReq), .dataWriteReq(dataWriteReq),
        .dataAddr(dataAddr), .dataWriteData(dataWriteData),
        .fetchDone(fetchDone), .fetchData(fetchData),
        .dataDone(dataDone), .dataReadData(dataReadData),
        .memAccessAddr(memAccessAddr), .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE), .memAccessWE(memAccessWE),
        .memAccessSerial(memAccessSerial), .memAccessBusy(memAccessBusy),
        .memReadDataReady(memReadDataReady), .memReadData(memReadData),
        .memReadSerial(memReadSerial)
    );

    // No memory traffic or repeated commit once halted
    assert property (@(posedge clk) disable iff (!arstN)
        phase == PH_HALTED |-> !memAccessRE && !memAccessWE
            && (!commitValid || $past(phase) != PH_HALTED));

endmodule : Core

`default_nettype wire

// File: hdl/MemoryAccessController.sv
// Memory request arbiter with serial-tagged responses
`timescale 1ns/1ns
`default_nettype none

module MemoryAccessController (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     fetchReq,
    input  CoreTypes::PC_Path         fetchAddr,
    input  logic                     dataReadReq,
    input  logic                     dataWriteReq,
    input  CoreTypes::AddrPath        dataAddr,
    input  CoreTypes::DataPath        dataWriteData,
    output logic                     fetchDone,
    output CoreTypes::DataPath        fetchData,
    output logic                     dataDone,
    output CoreTypes::DataPath        dataReadData,
    output CoreTypes::AddrPath        memAccessAddr,
    output CoreTypes::DataPath        memAccessWriteData,
    output logic                     memAccessRE,
    output logic                     memAccessWE,
    output CoreTypes::MemAccessSerial memAccessSerial,
    input  logic                     memAccessBusy,
    input  logic                     memReadDataReady,
    input  CoreTypes::DataPath        memReadData,
    input  CoreTypes::MemAccessSerial memReadSerial
);
    import CoreTypes::*;

    MemAccessSerial               nextSerial;
    logic [2**SERIAL_WIDTH-1:0]   entryValid;
    logic [2**SERIAL_WIDTH-1:0]   entryIsData;
    logic                         dataSel;
    logic                         readAccept;
    logic                         responseHit;

    // Data side wins over instruction fetch
    assign dataSel            = dataReadReq || dataWriteReq;
    assign memAccessRE        = dataReadReq || (fetchReq && !dataSel);
    assign memAccessWE        = dataWriteReq;
    assign memAccessAddr      = dataSel ? dataAddr : fetchAddr;
    assign memAccessWriteData = dataWriteData;
    assign memAccessSerial    = nextSerial;
    assign readAccept         = memAccessRE && !memAccessBusy;

    assign responseHit  = memReadDataReady && entryValid[memReadSerial];
    assign fetchDone    = responseHit && !entryIsData[memReadSerial];
    assign fetchData    = memReadData;
    assign dataReadData = memReadData;
    // Writes complete in the cycle memory takes them
    assign dataDone = (responseHit && entryIsData[memReadSerial])
                   || (dataWriteReq && !memAccessBusy);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            nextSerial <= '0;
            entryValid <= '0;
        end else begin
            if (memReadDataReady) begin
                entryValid[memReadSerial] <= 1'b0;
            end
            if (readAccept) begin
                entryValid[nextSerial] <= 1'b1;
                nextSerial <= nextSerial + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readAccept) begin
            entryIsData[nextSerial] <= dataReadReq;
        end
    end

    // Memory never returns a serial that was not issued
    assert property (@(posedge clk) disable iff (!arstN)
        memReadDataReady |-> entryValid[memReadSerial]);

endmodule : MemoryAccessController

`default_nettype wire

// File: hdl/LoadStoreUnit.sv
// Load/store path and serial output
`timescale 1ns/1ns
`default_nettype none

module LoadStoreUnit (
    input  logic               clk,
    input  logic               arstN,
    input  CoreTypes::CorePhase phase,
    input  logic               memRead,
    input  logic               memWrite,
    input  CoreTypes::AddrPath  memAddr,
    input  CoreTypes::DataPath  storeData,
    input  logic               dataDone,
    input  CoreTypes::DataPath  dataReadData,
    output logic               dataReadReq,
    output logic               dataWriteReq,
    output CoreTypes::AddrPath  dataAddr,
    output CoreTypes::DataPath  dataWriteData,
    output CoreTypes::DataPath  loadData,
    output logic               ioStore,
    output logic               serialWE,
    output CoreTypes::DataPath  serialWriteData
);
    import CoreTypes::*;

    logic    inExecute;
    logic    ioHit;
    DataPath loadDataQ;

    assign inExecute = phase == PH_EXECUTE;
    assign ioHit     = memAddr == SERIAL_IO_ADDR;

    // Any access to the I/O word finishes in the execute cycle
    assign ioStore       = inExecute && (memRead || memWrite) && ioHit;
    assign dataReadReq   = inExecute && memRead && !ioHit;
    assign dataWriteReq  = inExecute && memWrite && !ioHit;
    assign dataAddr      = memAddr;
    assign dataWriteData = storeData;

    // I/O loads read as zero
    assign loadData = (inExecute && ioHit) ? '0 : loadDataQ;

    always_ff @(posedge clk) begin
        if (dataDone && memRead) begin
            loadDataQ <= dataReadData;
        end
        if (ioStore && memWrite) begin
            serialWriteData <= storeData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            serialWE <= 1'b0;
        end else begin
            serialWE <= ioStore && memWrite;
        end
    end

endmodule : LoadStoreUnit

`default_nettype wire

// File: hdl/ExecuteUnit.sv
// Decoder, ALU and branch unit
`timescale 1ns/1ns
`default_nettype none

module ExecuteUnit (
    input  CoreTypes::DataPath    instruction,
    input  CoreTypes::DataPath    rs1Data,
    input  CoreTypes::DataPath    rs2Data,
    input  CoreTypes::DataPath    loadData,
    output CoreTypes::RegAddrPath rs1Addr,
    output CoreTypes::RegAddrPath rs2Addr,
    output CoreTypes::RegAddrPath rdAddr,
    output logic                 rdWrite,
    output CoreTypes::DataPath    rdData,
    output logic                 branchTaken,
    output CoreTypes::PC_Path     branchOffset,
    output logic                 memRead,
    output logic                 memWrite,
    output CoreTypes::AddrPath    memAddr,
    output CoreTypes::DataPath    storeData,
    output logic                 isHalt,
    output logic                 isIllegal
);
    import CoreTypes::*;

    OpCode   opCode;
    DataPath immExt;
    DataPath addrSum;

    assign opCode  = OpCode'(instruction[OPCODE_LSB +: $bits(OpCode)]);
    assign rdAddr  = instruction[RD_LSB +: REG_ADDR_WIDTH];
    assign rs1Addr = instruction[RS1_LSB +: REG_ADDR_WIDTH];
    assign rs2Addr = instruction[RS2_LSB +: REG_ADDR_WIDTH];

    assign immExt = {{(DATA_WIDTH - IMM_WIDTH){instruction[IMM_WIDTH-1]}},
                     instruction[IMM_WIDTH-1:0]};

    // Shared by ADDI and the load/store address
    assign addrSum      = rs1Data + immExt;
    assign memAddr      = addrSum[ADDR_WIDTH-1:0];
    assign branchOffset = immExt[ADDR_WIDTH-1:0];
    assign storeData    = rs2Data;

    always_comb begin
        rdWrite     = 1'b0;
        rdData      = addrSum;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        branchTaken = 1'b0;
        isHalt      = 1'b0;
        isIllegal   = 1'b0;
        case (opCode)
            OP_ADDI: begin
                rdWrite = 1'b1;
            end
            OP_ADD: begin
                rdWrite = 1'b1;
                rdData  = rs1Data + rs2Data;
            end
            OP_SUB: begin
                rdWrite = 1'b1;
                rdData  = rs1Data - rs2Data;
            end
            OP_LW: begin
                rdWrite = 1'b1;
                memRead = 1'b1;
                rdData  = loadData;
            end
            OP_SW:   memWrite = 1'b1;
            OP_BNE:  branchTaken = rs1Data != rs2Data;
            OP_HALT: isHalt = 1'b1;
            default: isIllegal = 1'b1;
        endcase
    end

endmodule : ExecuteUnit

`default_nettype wire

// File: hdl/FetchUnit.sv
// Program counter and instruction register
`timescale 1ns/1ns
`default_nettype none

module FetchUnit (
    input  logic               clk,
    input  logic               arstN,
    input  CoreTypes::CorePhase phase,
    input  logic               fetchDone,
    input  CoreTypes::DataPath  fetchData,
    input  logic               branchTaken,
    input  CoreTypes::PC_Path   branchOffset,
    input  logic               commitStrobe,
    output CoreTypes::PC_Path   pc,
    output CoreTypes::DataPath  instruction,
    output logic               fetchReq
);
    import CoreTypes::*;

    assign fetchReq = phase == PH_FETCH;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (commitStrobe) begin
            // Offset is in words, relative to the branch itself
            if (branchTaken) begin
                pc <= pc + branchOffset;
            end else begin
                pc <= pc + PC_Path'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instruction <= fetchData;
        end
    end

    // A fetch response must belong to the fetch the sequencer is waiting on
    assert property (@(posedge clk) disable iff (!arstN)
        fetchDone |-> phase == PH_FETCH_WAIT);

endmodule : FetchUnit

`default_nettype wire

// File: hdl/RegisterFile.sv
// Integer register file
`timescale 1ns/1ns
`default_nettype none

module RegisterFile (
    input  logic                 clk,
    input  logic                 arstN,
    input  CoreTypes::RegAddrPath readAddrA,
    input  CoreTypes::RegAddrPath readAddrB,
    output CoreTypes::DataPath    readDataA,
    output CoreTypes::DataPath    readDataB,
    input  logic                 writeEnable,
    input  CoreTypes::RegAddrPath writeAddr,
    input  CoreTypes::DataPath    writeData
);
    import CoreTypes::*;

    DataPath regs [REG_NUM];

    // r0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule : RegisterFile

`default_nettype wire

// File: hdl/CoreTypes.sv
// Core shared definitions
`default_nettype none

package CoreTypes;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 10;
    localparam int REG_NUM = 8;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int SERIAL_WIDTH = 2;
    localparam int MEM_READ_LATENCY = 3;

    typedef logic [DATA_WIDTH-1:0] DataPath;
    typedef logic [ADDR_WIDTH-1:0] AddrPath;
    typedef logic [ADDR_WIDTH-1:0] PC_Path;
    typedef logic [REG_ADDR_WIDTH-1:0] RegAddrPath;
    typedef logic [SERIAL_WIDTH-1:0] MemAccessSerial;

    // Stores to the top word go to the serial port
    localparam AddrPath SERIAL_IO_ADDR = '1;

    // Instruction field positions
    localparam int OPCODE_LSB = 28;
    localparam int RD_LSB = 25;
    localparam int RS1_LSB = 22;
    localparam int RS2_LSB = 19;
    localparam int IMM_WIDTH = 16;

    // Zero is left unassigned so that cleared memory traps
    typedef enum logic [3:0] {
        OP_ADDI = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_LW   = 4'h4,
        OP_SW   = 4'h5,
        OP_BNE  = 4'h6,
        OP_HALT = 4'hF
    } OpCode;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_FETCH,
        PH_FETCH_WAIT,
        PH_EXECUTE,
        PH_MEM_WAIT,
        PH_HALTED
    } CorePhase;

endpackage

`default_nettype wire
